// File: rtl/vid_macros.svh
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// Colour depth per channel as the game drives it
`define VID_COLORW 4

// One extra bit after the two-pixel blend
`define VID_ANAW (`VID_COLORW + 1)

// Display side colour depth
`define VID_OUTW 8

// OSD status word
`define VID_STATUS_W 64

// Bandwidth filter enable bit
`define VID_STATUS_BW_BIT 5

// Scanline field, three bits starting here
`define VID_STATUS_SL_LSB 2

`endif

// File: rtl/vid_pkg.sv
`include "vid_macros.svh"

package vid_pkg;

    // Raw game colour channel
    typedef logic [`VID_COLORW-1:0] game_color_t;

    // Channel after the bandwidth filter
    typedef logic [`VID_ANAW-1:0] ana_color_t;

    // Channel as sent to the display
    typedef logic [`VID_OUTW-1:0] out_color_t;

endpackage

// File: rtl/cfg_pkg.sv
`include "vid_macros.svh"

package cfg_pkg;

    // Whole OSD status word
    typedef logic [`VID_STATUS_W-1:0] status_t;

    // Scanline setting, only the low two bits reach the display
    typedef logic [2:0] sl_mode_t;

endpackage

// File: rtl/vid_settings.sv
`timescale 1ns/1ps
`include "vid_macros.svh"

module vid_settings (
    input  logic              clk_sys,
    input  logic              rst,
    input  cfg_pkg::status_t  status,
    output logic              bw_en,
    output cfg_pkg::sl_mode_t scanlines
);

    localparam int SL_W = $bits(cfg_pkg::sl_mode_t);

    // Video fields of the OSD word, held steady for the pixel path
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            bw_en     <= 1'b0;
            scanlines <= '0;
        end else begin
            bw_en     <= status[`VID_STATUS_BW_BIT];
            scanlines <= status[`VID_STATUS_SL_LSB +: SL_W];
        end
    end

    // Scanline mode feeds every pixel of the extend stage
    sl_known_a: assert property (
        @(posedge clk_sys) disable iff (rst)
        !$isunknown(scanlines)
    ) else $error("scanline mode unknown after reset");

endmodule

// File: rtl/vid_capture.sv
`timescale 1ns/1ps

module vid_capture (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  vid_pkg::game_color_t game_r,
    input  vid_pkg::game_color_t game_g,
    input  vid_pkg::game_color_t game_b,
    input  logic                 hs,
    input  logic                 vs,
    input  logic                 lhbl,
    input  logic                 lvbl,
    output vid_pkg::game_color_t cap_r,
    output vid_pkg::game_color_t cap_g,
    output vid_pkg::game_color_t cap_b,
    output logic                 cap_hs,
    output logic                 cap_vs,
    output logic                 cap_lhbl,
    output logic                 cap_lvbl
);

    // Colour and timing taken together so they stay aligned
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cap_r    <= '0;
            cap_g    <= '0;
            cap_b    <= '0;
            cap_hs   <= 1'b0;
            cap_vs   <= 1'b0;
            cap_lhbl <= 1'b0;
            cap_lvbl <= 1'b0;
        end else if (pxl_cen) begin
            cap_r    <= game_r;
            cap_g    <= game_g;
            cap_b    <= game_b;
            cap_hs   <= hs;
            cap_vs   <= vs;
            cap_lhbl <= lhbl;
            cap_lvbl <= lvbl;
        end
    end

    // Game must present a clean pixel on every strobe
    cap_known_a: assert property (
        @(posedge clk_sys) disable iff (rst)
        pxl_cen |=> !$isunknown({cap_r, cap_g, cap_b, cap_hs, cap_vs, cap_lhbl, cap_lvbl})
    ) else $error("unknown pixel captured");

endmodule

// File: rtl/vid_bwfilter.sv
`timescale 1ns/1ps

module vid_bwfilter (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic                 bw_en,
    input  vid_pkg::game_color_t cap_r,
    input  vid_pkg::game_color_t cap_g,
    input  vid_pkg::game_color_t cap_b,
    input  logic                 cap_hs,
    input  logic                 cap_vs,
    input  logic                 cap_lhbl,
    input  logic                 cap_lvbl,
    output vid_pkg::ana_color_t  ana_r,
    output vid_pkg::ana_color_t  ana_g,
    output vid_pkg::ana_color_t  ana_b,
    output logic                 ana_hs,
    output logic                 ana_vs,
    output logic                 ana_lhbl,
    output logic                 ana_lvbl
);

    // Previous captured pixel
    vid_pkg::game_color_t prev_r, prev_g, prev_b;

    // Sum of two neighbours, or the current pixel scaled to the same range
    function automatic vid_pkg::ana_color_t blend(
        input vid_pkg::game_color_t cur,
        input vid_pkg::game_color_t prev,
        input logic                 en
    );
        if (en) begin
            blend = {1'b0, cur} + {1'b0, prev};
        end else begin
            blend = {cur, 1'b0};
        end
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            prev_r   <= '0;
            prev_g   <= '0;
            prev_b   <= '0;
            ana_r    <= '0;
            ana_g    <= '0;
            ana_b    <= '0;
            ana_hs   <= 1'b0;
            ana_vs   <= 1'b0;
            ana_lhbl <= 1'b0;
            ana_lvbl <= 1'b0;
        end else if (pxl_cen) begin
            ana_r    <= blend(cap_r, prev_r, bw_en);
            ana_g    <= blend(cap_g, prev_g, bw_en);
            ana_b    <= blend(cap_b, prev_b, bw_en);
            prev_r   <= cap_r;
            prev_g   <= cap_g;
            prev_b   <= cap_b;
            // Timing delayed by the same single strobe
            ana_hs   <= cap_hs;
            ana_vs   <= cap_vs;
            ana_lhbl <= cap_lhbl;
            ana_lvbl <= cap_lvbl;
        end
    end

    // Blend relies on a pixel clock well below clk_sys
    cen_gap_a: assert property (
        @(posedge clk_sys) disable iff (rst)
        pxl_cen |=> !pxl_cen
    ) else $error("pxl_cen high on consecutive cycles");

endmodule

// File: rtl/vid_extend.sv
`timescale 1ns/1ps
`include "vid_macros.svh"

module vid_extend (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic                pxl_cen,
    input  cfg_pkg::sl_mode_t   scanlines,
    input  vid_pkg::ana_color_t ana_r,
    input  vid_pkg::ana_color_t ana_g,
    input  vid_pkg::ana_color_t ana_b,
    input  logic                ana_hs,
    input  logic                ana_vs,
    input  logic                ana_lhbl,
    input  logic                ana_lvbl,
    output vid_pkg::out_color_t scan2x_r,
    output vid_pkg::out_color_t scan2x_g,
    output vid_pkg::out_color_t scan2x_b,
    output logic                scan2x_hs,
    output logic                scan2x_vs,
    output logic                scan2x_de,
    output logic [1:0]          scan2x_sl
);

    localparam int FILL_W = `VID_OUTW - `VID_ANAW;

    // Top bits repeated below the value so full scale maps to 8'hff
    function automatic vid_pkg::out_color_t extend(input vid_pkg::ana_color_t a);
        extend = {a, a[`VID_ANAW-1 -: FILL_W]};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            scan2x_r  <= '0;
            scan2x_g  <= '0;
            scan2x_b  <= '0;
            scan2x_hs <= 1'b0;
            scan2x_vs <= 1'b0;
            scan2x_de <= 1'b0;
            scan2x_sl <= 2'd0;
        end else if (pxl_cen) begin
            scan2x_r  <= extend(ana_r);
            scan2x_g  <= extend(ana_g);
            scan2x_b  <= extend(ana_b);
            scan2x_hs <= ana_hs;
            scan2x_vs <= ana_vs;
            // Visible only outside both blanking intervals
            scan2x_de <= ana_lhbl & ana_lvbl;
            // Scanline mode travels with the pixel
            scan2x_sl <= scanlines[1:0];
        end
    end

endmodule

// File: rtl/vid_pipeline_top.sv
`timescale 1ns/1ps

module vid_pipeline_top (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  cfg_pkg::status_t     status,
    input  vid_pkg::game_color_t game_r,
    input  vid_pkg::game_color_t game_g,
    input  vid_pkg::game_color_t game_b,
    input  logic                 hs,
    input  logic                 vs,
    input  logic                 lhbl,
    input  logic                 lvbl,
    output vid_pkg::out_color_t  scan2x_r,
    output vid_pkg::out_color_t  scan2x_g,
    output vid_pkg::out_color_t  scan2x_b,
    output logic                 scan2x_hs,
    output logic                 scan2x_vs,
    output logic                 scan2x_de,
    output logic [1:0]           scan2x_sl
);

    logic                 bw_en;
    cfg_pkg::sl_mode_t    scanlines;

    // Capture to filter
    vid_pkg::game_color_t cap_r, cap_g, cap_b;
    logic                 cap_hs, cap_vs, cap_lhbl, cap_lvbl;

    // Filter to extend
    vid_pkg::ana_color_t  ana_r, ana_g, ana_b;
    logic                 ana_hs, ana_vs, ana_lhbl, ana_lvbl;

    vid_settings u_settings (
        .clk_sys   ( clk_sys   ),
        .rst       ( rst       ),
        .status    ( status    ),
        .bw_en     ( bw_en     ),
        .scanlines ( scanlines )
    );

    vid_capture u_capture (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .game_r   ( game_r   ),
        .game_g   ( game_g   ),
        .game_b   ( game_b   ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .cap_r    ( cap_r    ),
        .cap_g    ( cap_g    ),
        .cap_b    ( cap_b    ),
        .cap_hs   ( cap_hs   ),
        .cap_vs   ( cap_vs   ),
        .cap_lhbl ( cap_lhbl ),
        .cap_lvbl ( cap_lvbl )
    );

    vid_bwfilter u_bwfilter (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .bw_en    ( bw_en    ),
        .cap_r    ( cap_r    ),
        .cap_g    ( cap_g    ),
        .cap_b    ( cap_b    ),
        .cap_hs   ( cap_hs   ),
        .cap_vs   ( cap_vs   ),
        .cap_lhbl ( cap_lhbl ),
        .cap_lvbl ( cap_lvbl ),
        .ana_r    ( ana_r    ),
        .ana_g    ( ana_g    ),
        .ana_b    ( ana_b    ),
        .ana_hs   ( ana_hs   ),
        .ana_vs   ( ana_vs   ),
        .ana_lhbl ( ana_lhbl ),
        .ana_lvbl ( ana_lvbl )
    );

    vid_extend u_extend (
        .clk_sys   ( clk_sys   ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .scanlines ( scanlines ),
        .ana_r     ( ana_r     ),
        .ana_g     ( ana_g     ),
        .ana_b     ( ana_b     ),
        .ana_hs    ( ana_hs    ),
        .ana_vs    ( ana_vs    ),
        .ana_lhbl  ( ana_lhbl  ),
        .ana_lvbl  ( ana_lvbl  ),
        .scan2x_r  ( scan2x_r  ),
        .scan2x_g  ( scan2x_g  ),
        .scan2x_b  ( scan2x_b  ),
        .scan2x_hs ( scan2x_hs ),
        .scan2x_vs ( scan2x_vs ),
        .scan2x_de ( scan2x_de ),
        .scan2x_sl ( scan2x_sl )
    );

endmodule

// File: sim/vid_checker.sv
`timescale 1ns/1ps
`include "vid_macros.svh"

module vid_checker (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  cfg_pkg::status_t     status,
    input  vid_pkg::game_color_t game_r,
    input  vid_pkg::game_color_t game_g,
    input  vid_pkg::game_color_t game_b,
    input  logic                 hs,
    input  logic                 vs,
    input  logic                 lhbl,
    input  logic                 lvbl,
    input  vid_pkg::out_color_t  scan2x_r,
    input  vid_pkg::out_color_t  scan2x_g,
    input  vid_pkg::out_color_t  scan2x_b,
    input  logic                 scan2x_hs,
    input  logic                 scan2x_vs,
    input  logic                 scan2x_de,
    input  logic [1:0]           scan2x_sl,
    output int                   errors,
    output int                   checks
);

    // Pixels as {r, g, b, hs, vs, lhbl, lvbl}, newest first
    logic [15:0] hist[$];
    logic [15:0] cur;
    logic [15:0] prev;
    logic        bw;
    logic        armed = 1'b0;
    logic [7:0]  exp_r, exp_g, exp_b;
    logic        exp_hs, exp_vs, exp_de;
    logic [1:0]  exp_sl;
    int          err_n = 0;
    int          chk_n = 0;

    assign errors = err_n;
    assign checks = chk_n;

    // Sum of neighbours, or the current channel doubled
    function automatic logic [4:0] filtered(input logic [3:0] c, input logic [3:0] p,
                                            input logic en);
        filtered = en ? 5'(c) + 5'(p) : 5'(c) * 5'd2;
    endfunction

    // 5-bit value followed by its top three bits
    function automatic logic [7:0] expand(input logic [4:0] v);
        expand = {v, v[4:2]};
    endfunction

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
        chk_n++;
        if (got !== exp) begin
            err_n++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    always @(posedge clk_sys) begin
        if (rst) begin
            armed = 1'b1;
            hist.delete();
            // Pipeline holds zero pixels after reset
            repeat (3) hist.push_back(16'h0000);
            {exp_r, exp_g, exp_b} = '0;
            {exp_hs, exp_vs, exp_de, exp_sl} = '0;
        end else if (pxl_cen && armed) begin
            hist.push_front({game_r, game_g, game_b, hs, vs, lhbl, lvbl});
            // Output shows the pixel two strobes back
            cur  = hist[2];
            prev = hist[3];
            bw   = status[`VID_STATUS_BW_BIT];
            exp_r  = expand(filtered(cur[15:12], prev[15:12], bw));
            exp_g  = expand(filtered(cur[11:8], prev[11:8], bw));
            exp_b  = expand(filtered(cur[7:4], prev[7:4], bw));
            exp_hs = cur[3];
            exp_vs = cur[2];
            exp_de = cur[1] & cur[0];
            exp_sl = status[`VID_STATUS_SL_LSB +: 2];
            void'(hist.pop_back());
        end
    end

    // Every cycle, so held values are covered too
    always @(negedge clk_sys) begin
        if (armed && !rst) begin
            check_value("scan2x_r", exp_r, scan2x_r);
            check_value("scan2x_g", exp_g, scan2x_g);
            check_value("scan2x_b", exp_b, scan2x_b);
            check_value("scan2x_hs", {7'd0, exp_hs}, {7'd0, scan2x_hs});
            check_value("scan2x_vs", {7'd0, exp_vs}, {7'd0, scan2x_vs});
            check_value("scan2x_de", {7'd0, exp_de}, {7'd0, scan2x_de});
            check_value("scan2x_sl", {6'd0, exp_sl}, {6'd0, scan2x_sl});
        end
    end

endmodule

// File: sim/tb_vid_pipeline.sv
`timescale 1ns/1ps
`include "vid_macros.svh"

module tb_vid_pipeline;

    localparam int NTESTS = 5;

    // Per test OSD word, pixel count and start offset into the pixel table
    localparam logic [63:0] STATUS_TAB [NTESTS] = '{
        64'h0000_0000_0000_0000, 64'h0000_0000_0000_0024, 64'h0000_0000_0000_0008,
        64'h0000_0000_0000_0038, 64'ha5a5_0000_0000_003f
    };
    localparam int COUNT_TAB [NTESTS] = '{10, 12, 9, 11, 14};
    localparam int OFFSET_TAB [NTESTS] = '{0, 4, 8, 12, 3};

    // {r, g, b, hs, vs, lhbl, lvbl}
    localparam logic [15:0] PIX_TAB [16] = '{
        16'h1233, 16'hfff3, 16'hf0f1, 16'h0f02, 16'h8883, 16'h7773, 16'hfff3, 16'h0003,
        16'ha5c8, 16'h5a3c, 16'h3694, 16'hc3e3, 16'h9991, 16'h0002, 16'hedb3, 16'h4b6f
    };

    logic                 clk_sys;
    logic                 rst;
    logic                 pxl_cen;
    cfg_pkg::status_t     status;
    vid_pkg::game_color_t game_r, game_g, game_b;
    logic                 hs, vs, lhbl, lvbl;
    vid_pkg::out_color_t  scan2x_r, scan2x_g, scan2x_b;
    logic                 scan2x_hs, scan2x_vs, scan2x_de;
    logic [1:0]           scan2x_sl;
    int                   errors;
    int                   checks;
    logic [31:0]          rng = 32'h5a02;

    vid_pipeline_top dut0 (.*);

    vid_checker chk0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1103515245 + 32'd12345;
    endfunction

    // Worst case four cycles per strobe plus reset and settle per test
    function automatic int watchdog_ns();
        int cycles;
        cycles = 0;
        for (int t = 0; t < NTESTS; t++) begin
            cycles += (COUNT_TAB[t] + 3) * 4 + 6;
        end
        return cycles * 20 + 1000;
    endfunction

    task automatic send_pixel(input logic [15:0] p);
        int gap;
        {game_r, game_g, game_b} = p[15:4];
        {hs, vs, lhbl, lvbl} = p[3:0];
        pxl_cen = 1'b1;
        @(posedge clk_sys);
        #2;
        pxl_cen = 1'b0;
        rng = lcg_next(rng);
        gap = int'((rng >> 16) % 32'd3) + 1;
        // Junk on idle cycles must not reach the outputs
        {game_r, game_g, game_b} = rng[31:20];
        {hs, vs, lhbl, lvbl} = rng[11:8];
        repeat (gap) @(posedge clk_sys);
        #2;
    endtask

    task automatic apply_reset(input logic [63:0] s);
        rst = 1'b1;
        repeat (2) @(posedge clk_sys);
        #2;
        rst = 1'b0;
        status = s;
        repeat (2) @(posedge clk_sys);
        #2;
    endtask

    task automatic run_test(input int t);
        int         err_before;
        logic [3:0] idx;
        err_before = errors;
        apply_reset(STATUS_TAB[t]);
        for (int i = 0; i < COUNT_TAB[t]; i++) begin
            idx = 4'(OFFSET_TAB[t] + i);
            send_pixel(PIX_TAB[idx]);
        end
        // Full scale pixels push the last ones out and leave every stage loaded
        repeat (3) send_pixel(16'hffff);
        $display("test %0d: %0d pixels, bw_en %0d, scanline field %0d, %0d errors",
                 t, COUNT_TAB[t], STATUS_TAB[t][`VID_STATUS_BW_BIT],
                 STATUS_TAB[t][`VID_STATUS_SL_LSB +: 3], errors - err_before);
    endtask

    initial begin
        rst = 1'b1;
        pxl_cen = 1'b0;
        status = '0;
        {game_r, game_g, game_b} = '0;
        {hs, vs, lhbl, lvbl} = 4'b0000;
        @(posedge clk_sys);
        #2;
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
        end
        repeat (2) @(posedge clk_sys);
        $display("summary: %0d tests, %0d checks, %0d errors", NTESTS, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = watchdog_ns();
        #(limit);
        $display("timeout: run did not finish within %0d ns", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/vid_pkg.sv
rtl/cfg_pkg.sv
rtl/vid_settings.sv
rtl/vid_capture.sv
rtl/vid_bwfilter.sv
rtl/vid_extend.sv
rtl/vid_pipeline_top.sv
sim/vid_checker.sv
sim/tb_vid_pipeline.sv

// File: run.sh
#!/bin/sh
# Build and run the video pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vid_pipeline -f all.f -o vtb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vtb > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    exit 0
fi
exit 1
